// File: project.f
source/power_ctrl_pkg.sv
source/input_stage.sv
source/command_decoder.sv
source/charge_sequencer.sv
source/bridge_driver.sv
source/fault_monitor.sv
source/power_ctrl_top.sv
dv/power_ctrl_properties.sv
dv/power_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module power_ctrl_tb \
  -f project.f \
  -o power_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/power_ctrl_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi

// File: dv/power_ctrl_tb.sv
`timescale 1ns/1ps

module power_ctrl_tb;
  import power_ctrl_pkg::*;

  localparam int FILTER_WIDTH = 4;
  localparam int STEP_CYCLES  = 20;
  localparam int WAITSTATES   = 5;

  typedef enum logic [1:0] {FAULT_NONE, FAULT_GLITCH_U, FAULT_HOLD_DR2} fault_kind_t;

  typedef struct packed {
    logic start;
    logic charge;
    logic fan;
    logic brk;
  } ctrl_t;

  typedef struct packed {
    logic       stop;
    logic       avv;
    logic       avi;
    logic       td;
    logic [4:1] erbd;
  } ind_t;

  typedef struct packed {
    bridge_t bridge;
    ctrl_t   ctrl;
    ind_t    ind;
  } outs_t;

  typedef struct packed {
    logic [2:0]      n_codes;
    logic [3:0][2:0] codes;   // Slot 0 is sent first
    fault_kind_t     fault;
    int              settle;
    outs_t           want;
  } entry_t;

  // Bridge patterns as {top, bot, plus, minus, pause_p, pause_n}
  localparam bridge_t B_OFF   = '0;
  localparam bridge_t B_PLUS  = {4'b0001, 4'b0010, 4'b1000};
  localparam bridge_t B_MINUS = {4'b0010, 4'b0001, 4'b0100};
  localparam bridge_t B_BAL_P = {4'b0100, 4'b1000, 4'b0010};
  localparam bridge_t B_BAL_N = {4'b1000, 4'b0100, 4'b0001};

  // Control levels as {start, charge, fan, break}
  localparam logic [3:0] C_OFF      = 4'b0000;
  localparam logic [3:0] C_CHARGING = 4'b0110;
  localparam logic [3:0] C_MAIN_ON  = 4'b1110;  // Final wait step
  localparam logic [3:0] C_RUN      = 4'b1010;
  localparam logic [3:0] C_FAULT    = 4'b0011;

  logic       clk;
  logic       rstn;
  logic       i_strobe;
  logic [2:0] i_code;
  logic [4:1] i_err_dr_n;
  logic       i_err_u_n;
  logic       i_err_i_n;
  logic       i_bt;
  logic       i_stop_k_n;
  logic [4:1] o_top;
  logic [4:1] o_bot;
  logic       o_plus;
  logic       o_minus;
  logic       o_pause_p;
  logic       o_pause_n;
  logic       o_start;
  logic       o_charge;
  logic       o_charge_pwm;
  logic       o_fan;
  logic       o_break;
  logic       o_stop;
  logic       o_avv;
  logic       o_avi;
  logic       o_td;
  logic [4:1] o_erbd;

  entry_t tests_q[$];
  string  name_q[$];
  integer seed = 32'hde2d;
  int     cycle_limit = 0;
  int     cycle_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;

  power_ctrl_top #(
    .FILTER_WIDTH(FILTER_WIDTH),
    .STEP_CYCLES (STEP_CYCLES),
    .WAITSTATES  (WAITSTATES)
  ) dut0 (
    .clk(clk), .rstn(rstn), .i_strobe(i_strobe), .i_code(i_code),
    .i_err_dr_n(i_err_dr_n), .i_err_u_n(i_err_u_n), .i_err_i_n(i_err_i_n),
    .i_bt(i_bt), .i_stop_k_n(i_stop_k_n), .o_top(o_top), .o_bot(o_bot),
    .o_plus(o_plus), .o_minus(o_minus), .o_pause_p(o_pause_p), .o_pause_n(o_pause_n),
    .o_start(o_start), .o_charge(o_charge), .o_charge_pwm(o_charge_pwm), .o_fan(o_fan),
    .o_break(o_break), .o_stop(o_stop), .o_avv(o_avv), .o_avi(o_avi), .o_td(o_td),
    .o_erbd(o_erbd)
  );

  bind power_ctrl_top power_ctrl_properties u_props (
    .clk     (clk),
    .rstn    (rstn),
    .i_bridge(bridge),
    .i_break (o_break)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic void add_test(input string name, input int n,
                                   input logic [2:0] c0, input logic [2:0] c1,
                                   input logic [2:0] c2, input logic [2:0] c3,
                                   input fault_kind_t fault, input int settle,
                                   input bridge_t br, input logic [3:0] ctrl,
                                   input logic [4:1] erbd);
    entry_t e;
    e.n_codes   = 3'(n);
    e.codes     = {c3, c2, c1, c0};
    e.fault     = fault;
    e.settle    = settle;
    e.want      = '0;
    e.want.bridge    = br;
    e.want.ctrl      = ctrl_t'(ctrl);
    e.want.ind.erbd  = erbd;
    tests_q.push_back(e);
    name_q.push_back(name);
  endfunction

  // Upper bound on the cycles one entry takes
  function automatic int test_cycles(input entry_t e);
    int n;
    n = e.settle + 2;
    n += int'(e.n_codes) * (2 * (FILTER_WIDTH + 2) + 4);
    n += FILTER_WIDTH + 5;
    return n;
  endfunction

  function automatic outs_t sample_outs();
    outs_t o;
    o.bridge = {o_top, o_bot, o_plus, o_minus, o_pause_p, o_pause_n};
    o.ctrl   = {o_start, o_charge, o_fan, o_break};
    o.ind    = {o_stop, o_avv, o_avi, o_td, o_erbd};
    return o;
  endfunction

  task automatic send_strobe(input logic [2:0] code);
    int extra;
    extra = $random(seed) & 3;
    @(posedge clk);
    i_code   <= code;
    i_strobe <= 1'b1;
    repeat (FILTER_WIDTH + 2) @(posedge clk);
    i_strobe <= 1'b0;
    repeat (FILTER_WIDTH + 2 + extra) @(posedge clk);
  endtask

  task automatic inject_fault(input fault_kind_t kind);
    case (kind)
      FAULT_GLITCH_U: begin
        @(posedge clk);
        i_err_u_n <= 1'b0;                   // Too short for the filter
        repeat (FILTER_WIDTH - 2) @(posedge clk);
        i_err_u_n <= 1'b1;
      end
      FAULT_HOLD_DR2: begin
        @(posedge clk);
        i_err_dr_n[2] <= 1'b0;
        repeat (FILTER_WIDTH + 4) @(posedge clk);
        i_err_dr_n[2] <= 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic run_test(input int idx);
    entry_t e;
    outs_t  act;
    bit     ok;
    e  = tests_q[idx];
    ok = 1'b1;
    inject_fault(e.fault);
    for (int k = 0; k < int'(e.n_codes); k++) begin
      send_strobe(e.codes[k[1:0]]);
    end
    repeat (e.settle) @(posedge clk);
    @(negedge clk);                          // Sample away from the edge
    act = sample_outs();
    assert (act.bridge == e.want.bridge) else begin
      $display("[FAIL] %s bridge expected %b actual %b", name_q[idx],
               e.want.bridge, act.bridge);
      ok = 1'b0;
    end
    assert (act.ctrl == e.want.ctrl) else begin
      $display("[FAIL] %s start/charge/fan/break expected %b actual %b", name_q[idx],
               e.want.ctrl, act.ctrl);
      ok = 1'b0;
    end
    assert (act.ind == e.want.ind) else begin
      $display("[FAIL] %s indicators expected %b actual %b", name_q[idx],
               e.want.ind, act.ind);
      ok = 1'b0;
    end
    // PWM counter stays below the first duty step in this short run
    assert (o_charge_pwm == e.want.ctrl.charge) else begin
      $display("[FAIL] %s charge_pwm expected %b actual %b", name_q[idx],
               e.want.ctrl.charge, o_charge_pwm);
      ok = 1'b0;
    end
    if (ok) begin
      $display("[PASS] %s", name_q[idx]);
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
  endtask

  task automatic build_tests();
    add_test("reset_idle", 0, '0, '0, '0, '0, FAULT_NONE, 2, B_OFF, C_OFF, 4'b0000);
    add_test("plus_locked", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_OFF, 4'b0000);
    add_test("unlock", 4, CODE_DISCHARGE_KEY, CODE_PAUSE, CODE_DISCHARGE_KEY, CODE_PAUSE,
             FAULT_NONE, 10, B_OFF, C_OFF, 4'b0000);
    add_test("plus", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_PLUS, C_OFF, 4'b0000);
    add_test("minus", 1, CODE_MINUS, '0, '0, '0, FAULT_NONE, 20, B_MINUS, C_OFF, 4'b0000);
    add_test("ballast_p", 1, CODE_BALLAST_P, '0, '0, '0, FAULT_NONE, 20, B_BAL_P, C_OFF,
             4'b0000);
    add_test("ballast_n", 1, CODE_BALLAST_N, '0, '0, '0, FAULT_NONE, 20, B_BAL_N, C_OFF,
             4'b0000);
    add_test("pause", 1, CODE_PAUSE, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_OFF, 4'b0000);
    add_test("start", 2, CODE_START_PRE, CODE_PAUSE, '0, '0, FAULT_NONE, 10, B_OFF,
             C_CHARGING, 4'b0000);
    add_test("mid_ramp_plus", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_CHARGING,
             4'b0000);
    // Lands between the end of step 15 and the end of the final wait
    add_test("ramp_done", 0, '0, '0, '0, '0, FAULT_NONE, 264, B_OFF, C_MAIN_ON, 4'b0000);
    add_test("charge_done", 0, '0, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_RUN, 4'b0000);
    add_test("plus_after_ramp", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_PLUS, C_RUN,
             4'b0000);
    add_test("shutdown", 1, CODE_SHUTDOWN, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_OFF, 4'b0000);
    add_test("plus_after_shutdown", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_OFF,
             4'b0000);
    // Bridge left on so the glitch and the fault act on live outputs
    add_test("unlock_after_shutdown", 4, CODE_DISCHARGE_KEY, CODE_PAUSE, CODE_DISCHARGE_KEY,
             CODE_PAUSE, FAULT_NONE, 10, B_OFF, C_OFF, 4'b0000);
    add_test("plus_before_fault", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_PLUS, C_OFF,
             4'b0000);
    add_test("glitch_err_u", 0, '0, '0, '0, '0, FAULT_GLITCH_U, 20, B_PLUS, C_OFF, 4'b0000);
    add_test("fault_err_dr2", 0, '0, '0, '0, '0, FAULT_HOLD_DR2, 20, B_OFF, C_FAULT, 4'b0010);
    add_test("fault_unlock", 4, CODE_DISCHARGE_KEY, CODE_PAUSE, CODE_DISCHARGE_KEY, CODE_PAUSE,
             FAULT_NONE, 20, B_OFF, C_FAULT, 4'b0010);
    add_test("fault_plus", 1, CODE_PLUS, '0, '0, '0, FAULT_NONE, 20, B_OFF, C_FAULT, 4'b0010);
  endtask

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
    $display("tests failed");
    $finish;
  end

  initial begin
    int limit;
    rstn       <= 1'b0;
    i_strobe   <= 1'b0;
    i_code     <= 3'd0;
    i_err_dr_n <= 4'hf;                      // Fault lines idle high
    i_err_u_n  <= 1'b1;
    i_err_i_n  <= 1'b1;
    i_bt       <= 1'b0;
    i_stop_k_n <= 1'b1;
    build_tests();
    limit = 3 + 100;                         // Reset plus margin
    foreach (tests_q[i]) begin
      limit += test_cycles(tests_q[i]);
    end
    cycle_limit = limit;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < tests_q.size(); i++) begin
      run_test(i);
    end
    $display("Summary: %0d run, %0d ok, %0d with errors", tests_q.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: dv/power_ctrl_properties.sv
`timescale 1ns/1ps

module power_ctrl_properties (
  input logic                    clk,
  input logic                    rstn,
  input power_ctrl_pkg::bridge_t i_bridge,
  input logic                    i_break
);

  // No leg conducts top and bottom together
  a_no_shoot_through: assert property (@(posedge clk) disable iff (!rstn)
    (i_bridge.top & i_bridge.bot) == 4'b0000)
    else $error("Bridge leg has its top and bottom switch on together");

  // Bridge opens the cycle after break rises
  a_break_opens_bridge: assert property (@(posedge clk) disable iff (!rstn)
    i_break |=> (i_bridge == '0))
    else $error("Bridge outputs still active while break is high");

  a_single_top: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(i_bridge.top))
    else $error("More than one top switch is on");

endmodule

// File: source/power_ctrl_top.sv
`timescale 1ns/1ps

module power_ctrl_top #(
  parameter int FILTER_WIDTH = 8,
  parameter int STEP_CYCLES  = 100_000_000,  // 2 s at 50 MHz
  parameter int WAITSTATES   = 50
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       i_strobe,
  input  logic [2:0] i_code,
  input  logic [4:1] i_err_dr_n,
  input  logic       i_err_u_n,
  input  logic       i_err_i_n,
  input  logic       i_bt,
  input  logic       i_stop_k_n,
  output logic [4:1] o_top,
  output logic [4:1] o_bot,
  output logic       o_plus,
  output logic       o_minus,
  output logic       o_pause_p,
  output logic       o_pause_n,
  output logic       o_start,
  output logic       o_charge,
  output logic       o_charge_pwm,
  output logic       o_fan,
  output logic       o_break,
  output logic       o_stop,
  output logic       o_avv,
  output logic       o_avi,
  output logic       o_td,
  output logic [4:1] o_erbd
);
  import power_ctrl_pkg::*;

  filt_in_t       filt;
  cmd_t           cmd;
  charge_status_t status;
  bridge_t        bridge;
  logic           error;

  input_stage #(
    .FILTER_WIDTH(FILTER_WIDTH)
  ) u_input_stage (
    .clk       (clk),
    .rstn      (rstn),
    .i_strobe  (i_strobe),
    .i_code    (i_code),
    .i_err_dr_n(i_err_dr_n),
    .i_err_u_n (i_err_u_n),
    .i_err_i_n (i_err_i_n),
    .i_bt      (i_bt),
    .i_stop_k_n(i_stop_k_n),
    .o_filt    (filt)
  );

  command_decoder u_command_decoder (
    .clk    (clk),
    .rstn   (rstn),
    .i_filt (filt),
    .i_error(error),
    .o_cmd  (cmd)
  );

  charge_sequencer #(
    .STEP_CYCLES(STEP_CYCLES)
  ) u_charge_sequencer (
    .clk         (clk),
    .rstn        (rstn),
    .i_cmd       (cmd),
    .i_error     (error),
    .o_status    (status),
    .o_start     (o_start),
    .o_charge    (o_charge),
    .o_charge_pwm(o_charge_pwm),
    .o_fan       (o_fan)
  );

  bridge_driver #(
    .WAITSTATES(WAITSTATES)
  ) u_bridge_driver (
    .clk     (clk),
    .rstn    (rstn),
    .i_cmd   (cmd),
    .i_status(status),
    .i_error (error),
    .o_bridge(bridge)
  );

  fault_monitor u_fault_monitor (
    .clk     (clk),
    .rstn    (rstn),
    .i_faults(filt.faults),
    .o_error (error),
    .o_break (o_break),
    .o_stop  (o_stop),
    .o_avv   (o_avv),
    .o_avi   (o_avi),
    .o_td    (o_td),
    .o_erbd  (o_erbd)
  );

  // Bridge struct out to board pins
  assign o_top     = bridge.top;
  assign o_bot     = bridge.bot;
  assign o_plus    = bridge.plus;
  assign o_minus   = bridge.minus;
  assign o_pause_p = bridge.pause_p;
  assign o_pause_n = bridge.pause_n;

endmodule

// File: source/fault_monitor.sv
`timescale 1ns/1ps

module fault_monitor (
  input  logic                   clk,
  input  logic                   rstn,
  input  power_ctrl_pkg::fault_t i_faults,
  output logic                   o_error,
  output logic                   o_break,
  output logic                   o_stop,
  output logic                   o_avv,
  output logic                   o_avi,
  output logic                   o_td,
  output logic [4:1]             o_erbd
);
  import power_ctrl_pkg::*;

  fault_t seen_q;   // Every fault ever seen since reset
  logic   error_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      seen_q  <= '0;
      error_q <= 1'b0;
    end else begin
      seen_q  <= seen_q | i_faults;
      error_q <= error_q | (|i_faults);  // Sticky until reset
    end
  end

  assign o_error = error_q;
  assign o_break = error_q;
  assign o_stop  = seen_q.stop_k;
  assign o_avv   = seen_q.err_u;
  assign o_avi   = seen_q.err_i;
  assign o_td    = seen_q.bt;
  assign o_erbd  = seen_q.err_dr;

endmodule

// File: source/bridge_driver.sv
`timescale 1ns/1ps

module bridge_driver #(
  parameter int WAITSTATES = 50
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  power_ctrl_pkg::cmd_t           i_cmd,
  input  power_ctrl_pkg::charge_status_t i_status,
  input  logic                           i_error,
  output power_ctrl_pkg::bridge_t        o_bridge
);
  import power_ctrl_pkg::*;

  localparam int WS_W = $clog2(WAITSTATES + 1);

  bridge_t         bridge_q;
  bridge_t         next_q;     // Pattern waiting for dead time
  logic [WS_W-1:0] ws_q;
  logic            pending_q;
  logic            is_pattern;
  logic            pattern_ok;
  logic            clear_req;

  function automatic bridge_t pattern_of(input cmd_kind_t kind);
    bridge_t p;
    p = '0;
    case (kind)
      CMD_PLUS: begin
        p.top  = 4'b0001;
        p.bot  = 4'b0010;
        p.plus = 1'b1;
      end
      CMD_MINUS: begin
        p.top   = 4'b0010;
        p.bot   = 4'b0001;
        p.minus = 1'b1;
      end
      CMD_BALLAST_P: begin
        p.top     = 4'b0100;
        p.bot     = 4'b1000;
        p.pause_p = 1'b1;
      end
      CMD_BALLAST_N: begin
        p.top     = 4'b1000;
        p.bot     = 4'b0100;
        p.pause_n = 1'b1;
      end
      default: p = '0;
    endcase
    return p;
  endfunction

  assign is_pattern = i_cmd.kind inside {CMD_PLUS, CMD_MINUS, CMD_BALLAST_P, CMD_BALLAST_N};
  assign pattern_ok = i_cmd.valid & is_pattern & i_status.ready & ~i_status.busy & ~pending_q;
  // Start also opens the bridge before charging
  assign clear_req  = i_cmd.valid & ((i_cmd.kind == CMD_SHUTDOWN) |
                                     (i_cmd.kind == CMD_PAUSE & ~i_status.busy) |
                                     (i_cmd.kind == CMD_START & ~i_status.busy));

  always_ff @(posedge clk) begin
    if (pattern_ok) begin
      next_q <= pattern_of(i_cmd.kind);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bridge_q  <= '0;
      ws_q      <= '0;
      pending_q <= 1'b0;
    end else if (i_error || clear_req) begin
      bridge_q  <= '0;
      ws_q      <= '0;
      pending_q <= 1'b0;  // Cancel any pending pattern
    end else if (pattern_ok) begin
      bridge_q  <= '0;    // All switches off during dead time
      ws_q      <= WS_W'(WAITSTATES);
      pending_q <= 1'b1;
    end else if (pending_q) begin
      if (ws_q != '0) begin
        ws_q <= ws_q - 1'b1;
      end else begin
        bridge_q  <= next_q;
        pending_q <= 1'b0;
      end
    end
  end

  assign o_bridge = bridge_q;

endmodule

// File: source/charge_sequencer.sv
`timescale 1ns/1ps

module charge_sequencer #(
  parameter int STEP_CYCLES = 100_000_000
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  power_ctrl_pkg::cmd_t           i_cmd,
  input  logic                           i_error,
  output power_ctrl_pkg::charge_status_t o_status,
  output logic                           o_start,
  output logic                           o_charge,
  output logic                           o_charge_pwm,
  output logic                           o_fan
);
  import power_ctrl_pkg::*;

  localparam int TIMER_W = $clog2(STEP_CYCLES + 1);
  localparam logic [TIMER_W-1:0] TIMER_RELOAD = TIMER_W'(STEP_CYCLES - 1);
  localparam logic [4:0] LAST_RAMP = 5'(ramp_steps);

  logic [4:0]         step_q;  // 0 idle, 1 to 15 ramp, 16 final wait
  logic [TIMER_W-1:0] timer_q;
  duty_t              duty_q;
  duty_t              pwm_cnt_q;
  logic               ready_q;
  logic               start_q;
  logic               charge_q;
  logic               fan_q;
  logic               busy;
  logic               step_done;

  assign busy      = (step_q != '0);
  assign step_done = (timer_q == '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      step_q    <= '0;
      timer_q   <= '0;
      duty_q    <= '0;
      pwm_cnt_q <= '0;
      ready_q   <= 1'b0;
      start_q   <= 1'b0;
      charge_q  <= 1'b0;
      fan_q     <= 1'b0;
    end else begin
      pwm_cnt_q <= pwm_cnt_q + 1'b1;  // Free running
      if (i_error) begin
        step_q   <= '0;
        timer_q  <= '0;
        duty_q   <= '0;
        ready_q  <= 1'b0;
        start_q  <= 1'b0;
        charge_q <= 1'b0;
        fan_q    <= 1'b1;              // Keep cooling after a fault
      end else if (i_cmd.valid && i_cmd.kind == CMD_SHUTDOWN) begin
        step_q   <= '0;
        timer_q  <= '0;
        duty_q   <= '0;
        ready_q  <= 1'b0;
        start_q  <= 1'b0;
        charge_q <= 1'b0;
        fan_q    <= 1'b0;
      end else begin
        if (i_cmd.valid && i_cmd.kind == CMD_UNLOCK) begin
          ready_q <= 1'b1;
        end
        if (busy) begin
          if (step_done) begin
            timer_q <= TIMER_RELOAD;
            step_q  <= step_q + 1'b1;
            if (step_q < LAST_RAMP) begin
              duty_q <= ramp_duty[step_q[3:0]];  // Next step's duty
            end else if (step_q == LAST_RAMP) begin
              start_q <= 1'b1;                   // Ramp done, close main contactor
            end else begin
              step_q   <= '0;                    // End of final wait
              charge_q <= 1'b0;
              duty_q   <= '0;
              ready_q  <= 1'b1;
            end
          end else begin
            timer_q <= timer_q - 1'b1;
          end
        end else if (i_cmd.valid && i_cmd.kind == CMD_START) begin
          step_q   <= 5'd1;
          timer_q  <= TIMER_RELOAD;
          duty_q   <= ramp_duty[0];
          fan_q    <= 1'b1;
          charge_q <= 1'b1;
          start_q  <= 1'b0;
        end
      end
    end
  end

  assign o_status.ready = ready_q;
  assign o_status.busy  = busy;
  assign o_start        = start_q;
  assign o_charge       = charge_q;
  assign o_fan          = fan_q;
  // All-ones duty means fully on
  assign o_charge_pwm   = charge_q & ((pwm_cnt_q < duty_q) | (&duty_q));

endmodule

// File: source/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
  input  logic                     clk,
  input  logic                     rstn,
  input  power_ctrl_pkg::filt_in_t i_filt,
  input  logic                     i_error,
  output power_ctrl_pkg::cmd_t     o_cmd
);
  import power_ctrl_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    START_ARMED,  // Code 5 seen
    KEY1,         // Code 7 seen
    KEY2,         // Codes 7, 0 seen
    KEY3          // Codes 7, 0, 7 seen
  } dec_state_t;

  dec_state_t state_q;
  dec_state_t state_d;
  cmd_t       cmd_d;
  logic       strobe_q;
  logic       strobe_fall;

  function automatic cmd_kind_t code_to_kind(input cmd_code_t code);
    cmd_kind_t kind;
    case (code)
      CODE_PLUS:      kind = CMD_PLUS;
      CODE_MINUS:     kind = CMD_MINUS;
      CODE_BALLAST_P: kind = CMD_BALLAST_P;
      CODE_BALLAST_N: kind = CMD_BALLAST_N;
      CODE_SHUTDOWN:  kind = CMD_SHUTDOWN;
      default:        kind = CMD_PAUSE;
    endcase
    return kind;
  endfunction

  assign strobe_fall = strobe_q & ~i_filt.strobe;

  always_comb begin
    state_d    = state_q;
    cmd_d      = '0;
    if (i_error) begin
      state_d = IDLE;  // Locked out after a fault
    end else if (strobe_fall) begin
      state_d = IDLE;  // Wrong code in a sequence aborts it
      case (state_q)
        IDLE: begin
          case (i_filt.code)
            CODE_START_PRE:     state_d = START_ARMED;
            CODE_DISCHARGE_KEY: state_d = KEY1;
            default: begin
              cmd_d.valid = 1'b1;
              cmd_d.kind  = code_to_kind(i_filt.code);
            end
          endcase
        end
        START_ARMED: begin
          if (i_filt.code == CODE_PAUSE) begin
            cmd_d.valid = 1'b1;
            cmd_d.kind  = CMD_START;
          end
        end
        KEY1: begin
          if (i_filt.code == CODE_PAUSE) begin
            state_d = KEY2;
          end
        end
        KEY2: begin
          if (i_filt.code == CODE_DISCHARGE_KEY) begin
            state_d = KEY3;
          end
        end
        KEY3: begin
          if (i_filt.code == CODE_PAUSE) begin
            cmd_d.valid = 1'b1;
            cmd_d.kind  = CMD_UNLOCK;
          end
        end
        default: state_d = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= IDLE;
      strobe_q <= 1'b0;
      o_cmd    <= '0;
    end else begin
      state_q  <= state_d;
      strobe_q <= i_filt.strobe;
      o_cmd    <= cmd_d;
    end
  end

endmodule

// File: source/input_stage.sv
`timescale 1ns/1ps

module input_stage #(
  parameter int FILTER_WIDTH = 8
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     i_strobe,
  input  logic [2:0]               i_code,
  input  logic [4:1]               i_err_dr_n,
  input  logic                     i_err_u_n,
  input  logic                     i_err_i_n,
  input  logic                     i_bt,
  input  logic                     i_stop_k_n,
  output power_ctrl_pkg::filt_in_t o_filt
);
  import power_ctrl_pkg::*;

  localparam int NUM_LINES = $bits(filt_in_t);
  localparam int CNT_W     = $clog2(FILTER_WIDTH + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FILTER_WIDTH - 1);

  filt_in_t             raw;
  logic [NUM_LINES-1:0] sync_q;                  // Input capture stage
  logic [NUM_LINES-1:0] filt_q;
  logic [CNT_W-1:0]     stable_cnt [NUM_LINES];  // Cycles since line differs

  always_comb begin
    raw.strobe        = i_strobe;
    raw.code          = cmd_code_t'(i_code);
    raw.faults.err_dr = ~i_err_dr_n;  // Active low on the board
    raw.faults.err_u  = ~i_err_u_n;
    raw.faults.err_i  = ~i_err_i_n;
    raw.faults.bt     = i_bt;         // Already active high
    raw.faults.stop_k = ~i_stop_k_n;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sync_q <= '0;
      filt_q <= '0;
      for (int i = 0; i < NUM_LINES; i++) begin
        stable_cnt[i] <= '0;
      end
    end else begin
      sync_q <= raw;
      for (int i = 0; i < NUM_LINES; i++) begin
        if (sync_q[i] == filt_q[i]) begin
          stable_cnt[i] <= '0;             // Glitch ended, start over
        end else if (stable_cnt[i] == CNT_LAST) begin
          filt_q[i]     <= sync_q[i];
          stable_cnt[i] <= '0;
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign o_filt = filt_in_t'(filt_q);

endmodule

// File: source/power_ctrl_pkg.sv
package power_ctrl_pkg;

  localparam int pwm_width  = 19;  // Charge PWM counter and duty width
  localparam int ramp_steps = 15;  // Soft-start duty steps

  typedef logic [pwm_width-1:0] duty_t;

  // Duty per soft-start step, index 0 is step 1
  // The last four steps are all ones, so the PWM stays on
  localparam duty_t ramp_duty [ramp_steps] = '{
    19'd131072, 19'd131072, 19'd131072, 19'd131072,
    19'd262144, 19'd262144, 19'd262144, 19'd262144,
    19'd393216, 19'd393216, 19'd393216,
    19'h7ffff,  19'h7ffff,  19'h7ffff,  19'h7ffff
  };

  // Raw codes on the 3-bit command bus
  typedef enum logic [2:0] {
    CODE_PAUSE         = 3'd0,
    CODE_PLUS          = 3'd1,
    CODE_MINUS         = 3'd2,
    CODE_BALLAST_P     = 3'd3,
    CODE_BALLAST_N     = 3'd4,
    CODE_START_PRE     = 3'd5,
    CODE_SHUTDOWN      = 3'd6,
    CODE_DISCHARGE_KEY = 3'd7
  } cmd_code_t;

  // Commands after sequence decoding
  typedef enum logic [2:0] {
    CMD_PAUSE,
    CMD_PLUS,
    CMD_MINUS,
    CMD_BALLAST_P,
    CMD_BALLAST_N,
    CMD_START,
    CMD_SHUTDOWN,
    CMD_UNLOCK
  } cmd_kind_t;

  typedef struct packed {
    logic      valid;  // One-cycle pulse
    cmd_kind_t kind;
  } cmd_t;

  typedef struct packed {
    logic [4:1] err_dr;  // Driver faults, one per leg
    logic       err_u;   // Overvoltage
    logic       err_i;   // Overcurrent
    logic       bt;      // Overtemperature
    logic       stop_k;  // Emergency stop
  } fault_t;

  typedef struct packed {
    logic      strobe;
    cmd_code_t code;
    fault_t    faults;
  } filt_in_t;

  typedef struct packed {
    logic [4:1] top;
    logic [4:1] bot;
    logic       plus;
    logic       minus;
    logic       pause_p;
    logic       pause_n;
  } bridge_t;

  typedef struct packed {
    logic ready;  // Bridge patterns allowed
    logic busy;   // Soft start running
  } charge_status_t;

endpackage
